//--- Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = tb_soc_subsystem
FILELIST   = src.f
PASS_TEXT  = Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

//--- bench/tb_clock.sv
// Testbench clock source, 20 ns period

`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clock
);

  localparam real HALF_PERIOD = 10.0;

  initial begin
    clock = 1'b0;
  end

  always #(HALF_PERIOD) clock = ~clock;

endmodule

`default_nettype wire

//--- bench/tb_soc_subsystem.sv
// Testbench of the device subsystem: bus tasks, checking
// assertions for latency, RAM, unmapped, GPIO and timer behavior

`timescale 1ns/1ps
`default_nettype none
`include "soc_settings.svh"

module tb_soc_subsystem
  import periph_pkg::*;
();

  localparam int          GPIO_W        = `SOC_GPIO_WIDTH;
  localparam logic [31:0] GPIO_MASK     = (32'h1 << GPIO_W) - 32'h1;
  localparam logic [31:0] RAM_WORD_MASK = (`SOC_MEMORY_SIZE / 4) - 1;
  localparam logic [31:0] UNMAPPED_ADDR = 32'h4000_0000;
  localparam logic [31:0] GPIO_IN_ADDR  = `SOC_GPIO_BASE + 32'(REG_GPIO_IN);
  localparam logic [31:0] GPIO_OE_ADDR  = `SOC_GPIO_BASE + 32'(REG_GPIO_OE);
  localparam logic [31:0] GPIO_OUT_ADDR = `SOC_GPIO_BASE + 32'(REG_GPIO_OUT);
  localparam logic [31:0] MT_CTRL_ADDR  = `SOC_MTIMER_BASE + 32'(REG_MT_CTRL);
  localparam logic [31:0] MT_TLO_ADDR   = `SOC_MTIMER_BASE + 32'(REG_MT_TIME_LO);
  localparam logic [31:0] MT_THI_ADDR   = `SOC_MTIMER_BASE + 32'(REG_MT_TIME_HI);
  localparam logic [31:0] MT_CLO_ADDR   = `SOC_MTIMER_BASE + 32'(REG_MT_CMP_LO);
  localparam logic [31:0] MT_CHI_ADDR   = `SOC_MTIMER_BASE + 32'(REG_MT_CMP_HI);
  localparam int          IRQ_DELAY     = 40;

  logic              clock;
  logic              rst_n;
  logic [31:0]       rw_address;
  logic [31:0]       write_data;
  logic [3:0]        write_strobe;
  logic              read_request;
  logic              write_request;
  logic [31:0]       read_data;
  logic              read_response;
  logic              write_response;
  logic [GPIO_W-1:0] gpio_input;
  logic [GPIO_W-1:0] gpio_oe;
  logic [GPIO_W-1:0] gpio_output;
  logic              irq_timer;

  int                check_errors = 0;
  int                timeout_errors = 0;
  int                cycle_count = 0;
  int                last_request_cycle = 0;
  integer            seed;

  // Expectations armed by the stimulus
  logic              check_read = 1'b0;
  logic [31:0]       expected_read = 32'h0;
  logic              check_gpio = 1'b0;
  logic [GPIO_W-1:0] expected_oe = '0;
  logic [GPIO_W-1:0] expected_out = '0;
  logic              check_irq_high = 1'b0;

  // RAM shadow model
  logic [31:0]       shadow [logic [31:0]];
  logic [31:0]       ram_addresses [$];

  tb_clock tb_clock_i (.clock(clock));

  soc_subsystem soc_subsystem_i (
    .clock          (clock),
    .rst_n          (rst_n),
    .rw_address     (rw_address),
    .write_data     (write_data),
    .write_strobe   (write_strobe),
    .read_request   (read_request),
    .write_request  (write_request),
    .read_data      (read_data),
    .read_response  (read_response),
    .write_response (write_response),
    .gpio_input     (gpio_input),
    .gpio_oe        (gpio_oe),
    .gpio_output    (gpio_output),
    .irq_timer      (irq_timer)
  );

  always @(posedge clock) cycle_count <= cycle_count + 1;

  // ----------------------------------------------------------
  // Checking assertions
  // ----------------------------------------------------------
  assert property (@(posedge clock) disable iff (!rst_n) read_request |=> read_response)
    else begin
      check_errors = check_errors + 1;
      $display("MISMATCH read_response: expected 0x1, actual 0x0");
    end

  assert property (@(posedge clock) disable iff (!rst_n) read_response |-> $past(read_request))
    else begin
      check_errors = check_errors + 1;
      $display("Read response seen without a read request in the cycle before");
    end

  assert property (@(posedge clock) disable iff (!rst_n) write_request |=> write_response)
    else begin
      check_errors = check_errors + 1;
      $display("MISMATCH write_response: expected 0x1, actual 0x0");
    end

  assert property (@(posedge clock) disable iff (!rst_n)
    write_response |-> $past(write_request))
    else begin
      check_errors = check_errors + 1;
      $display("Write response seen without a write request in the cycle before");
    end

  assert property (@(posedge clock) disable iff (!rst_n)
    (read_response && check_read) |-> (read_data == expected_read))
    else begin
      check_errors = check_errors + 1;
      $display("MISMATCH read_data: expected 0x%08h, actual 0x%08h",
               $sampled(expected_read), $sampled(read_data));
    end

  // Outputs settle one cycle after the write response
  assert property (@(posedge clock) disable iff (!rst_n)
    (write_response && check_gpio) |=> (gpio_oe == expected_oe))
    else begin
      check_errors = check_errors + 1;
      $display("MISMATCH gpio_oe: expected 0x%h, actual 0x%h",
               $sampled(expected_oe), $sampled(gpio_oe));
    end

  assert property (@(posedge clock) disable iff (!rst_n)
    (write_response && check_gpio) |=> (gpio_output == expected_out))
    else begin
      check_errors = check_errors + 1;
      $display("MISMATCH gpio_output: expected 0x%h, actual 0x%h",
               $sampled(expected_out), $sampled(gpio_output));
    end

  assert property (@(posedge clock) disable iff (!rst_n) check_irq_high |-> irq_timer)
    else begin
      check_errors = check_errors + 1;
      $display("MISMATCH irq_timer: expected 0x1, actual 0x0");
    end

  // ----------------------------------------------------------
  // Bus tasks
  // ----------------------------------------------------------
  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strobe);
    int waited;
    @(negedge clock);
    rw_address         = addr;
    write_data         = data;
    write_strobe       = strobe;
    write_request      = 1'b1;
    last_request_cycle = cycle_count + 1;
    @(negedge clock);
    write_request = 1'b0;
    waited = 0;
    while (!write_response && waited < 20) begin
      @(negedge clock);
      waited++;
    end
    if (!write_response) begin
      timeout_errors++;
      $display("Timeout: no write response for address 0x%08h", addr);
    end
    @(negedge clock);
  endtask

  task automatic bus_read(input logic [31:0] addr, input logic check,
                          input logic [31:0] expected, output logic [31:0] data);
    int waited;
    @(negedge clock);
    check_read         = check;
    expected_read      = expected;
    rw_address         = addr;
    read_request       = 1'b1;
    last_request_cycle = cycle_count + 1;
    @(negedge clock);
    read_request = 1'b0;
    waited = 0;
    while (!read_response && waited < 20) begin
      @(negedge clock);
      waited++;
    end
    data = read_data;
    if (!read_response) begin
      timeout_errors++;
      $display("Timeout: no read response for address 0x%08h", addr);
    end
    @(negedge clock);
  endtask

  // Shadow model of a strobed write
  function automatic logic [31:0] apply_strobe(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0]  strobe);
    logic [31:0] mask;
    mask = {{8{strobe[3]}}, {8{strobe[2]}}, {8{strobe[1]}}, {8{strobe[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------
  initial begin
    logic [31:0] addr;
    logic [31:0] value;
    logic [31:0] data;
    logic [31:0] t1;
    logic [31:0] t2;
    int          c1;
    int          c2;
    int          waited;
    rst_n         = 1'b0;
    rw_address    = 32'h0;
    write_data    = 32'h0;
    write_strobe  = 4'h0;
    read_request  = 1'b0;
    write_request = 1'b0;
    gpio_input    = '0;
    seed          = 31;
    repeat (10) @(negedge clock);
    rst_n = 1'b1;
    repeat (2) @(negedge clock);

    // Random words to random aligned RAM addresses
    for (int i = 0; i < 16; i++) begin
      addr  = `SOC_RAM_BASE + (($random(seed) & RAM_WORD_MASK) << 2);
      value = $random(seed);
      bus_write(addr, value, 4'hF);
      shadow[addr] = value;
      ram_addresses.push_back(addr);
    end
    foreach (ram_addresses[i])
      bus_read(ram_addresses[i], 1'b1, shadow[ram_addresses[i]], data);

    // Partial strobe on a known word
    bus_write(`SOC_RAM_BASE + 32'h100, 32'h1122_3344, 4'hF);
    bus_write(`SOC_RAM_BASE + 32'h100, 32'hAABB_CCDD, 4'b0101);
    bus_read(`SOC_RAM_BASE + 32'h100, 1'b1,
             apply_strobe(32'h1122_3344, 32'hAABB_CCDD, 4'b0101), data);

    // Unmapped address reads zero and leaves word 0 alone
    bus_write(`SOC_RAM_BASE, 32'h5A5A_0001, 4'hF);
    bus_read(UNMAPPED_ADDR, 1'b1, 32'h0, data);
    bus_write(UNMAPPED_ADDR, 32'hFFFF_FFFF, 4'hF);
    bus_read(`SOC_RAM_BASE, 1'b1, 32'h5A5A_0001, data);

    // GPIO registers and pins
    check_gpio = 1'b1;
    for (int i = 0; i < 4; i++) begin
      value       = $random(seed);
      expected_oe = value[GPIO_W-1:0];
      bus_write(GPIO_OE_ADDR, value, 4'hF);
      bus_read(GPIO_OE_ADDR, 1'b1, value & GPIO_MASK, data);
      value        = $random(seed);
      expected_out = value[GPIO_W-1:0];
      bus_write(GPIO_OUT_ADDR, value, 4'hF);
      bus_read(GPIO_OUT_ADDR, 1'b1, value & GPIO_MASK, data);
    end
    check_gpio = 1'b0;
    for (int i = 0; i < 4; i++) begin
      value      = $random(seed);
      gpio_input = value[GPIO_W-1:0];
      repeat (2) @(negedge clock);
      bus_read(GPIO_IN_ADDR, 1'b1, value & GPIO_MASK, data);
    end

    // Timer counts one per clock
    bus_write(MT_CTRL_ADDR, 32'h0, 4'hF);
    bus_write(MT_THI_ADDR, 32'h0, 4'hF);
    bus_write(MT_TLO_ADDR, 32'h0, 4'hF);
    bus_write(MT_CTRL_ADDR, 32'h1, 4'hF);
    bus_read(MT_TLO_ADDR, 1'b0, 32'h0, t1);
    c1 = last_request_cycle;
    value = ($random(seed) & 32'hF) + 32'd5;
    repeat (value) @(negedge clock);
    bus_read(MT_TLO_ADDR, 1'b0, 32'h0, t2);
    c2 = last_request_cycle;
    assert (t2 - t1 == 32'(c2 - c1))
      else begin
        check_errors++;
        $display("MISMATCH mtime delta: expected 0x%08h, actual 0x%08h",
                 32'(c2 - c1), t2 - t1);
      end

    // Compare match raises the interrupt level
    bus_write(MT_CTRL_ADDR, 32'h0, 4'hF);
    bus_write(MT_THI_ADDR, 32'h0, 4'hF);
    bus_write(MT_TLO_ADDR, 32'h0, 4'hF);
    bus_write(MT_CHI_ADDR, 32'h0, 4'hF);
    bus_write(MT_CLO_ADDR, 32'(IRQ_DELAY), 4'hF);
    bus_write(MT_CTRL_ADDR, 32'h1, 4'hF);
    c1 = last_request_cycle;
    waited = 0;
    while (!irq_timer && waited < IRQ_DELAY + 20) begin
      @(negedge clock);
      waited++;
    end
    if (!irq_timer) begin
      timeout_errors++;
      $display("Timeout: irq_timer never rose after the compare value was set");
    end else begin
      c2 = cycle_count;
      assert (c2 - c1 >= IRQ_DELAY - 2 && c2 - c1 <= IRQ_DELAY + 2)
        else begin
          check_errors++;
          $display("irq_timer rose after %0d cycles instead of about %0d",
                   c2 - c1, IRQ_DELAY);
        end
    end
    check_irq_high = 1'b1;
    repeat (10) @(negedge clock);
    check_irq_high = 1'b0;

    // Larger compare value drops the level
    bus_write(MT_CHI_ADDR, 32'h1, 4'hF);
    waited = 0;
    while (irq_timer && waited < 2) begin
      @(negedge clock);
      waited++;
    end
    assert (!irq_timer)
      else begin
        check_errors++;
        $display("irq_timer stayed high after mtimecmp was raised above mtime");
      end

    repeat (3) @(negedge clock);
    $display("Error count: %0d failed checks, %0d timeouts", check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+verilog
verilog/bus_pkg.sv
verilog/periph_pkg.sv
verilog/system_bus.sv
verilog/soc_ram.sv
verilog/soc_gpio.sv
verilog/soc_mtimer.sv
verilog/soc_subsystem.sv
bench/tb_clock.sv
bench/tb_soc_subsystem.sv

//--- verilog/bus_pkg.sv
// Device index and decoded address word of the system bus

`default_nettype none

package bus_pkg;

  // Bus targets with DEV_NONE for an unmapped address
  typedef enum logic [1:0] {
    DEV_RAM    = 2'd0,
    DEV_MTIMER = 2'd1,
    DEV_GPIO   = 2'd2,
    DEV_NONE   = 2'd3
  } device_index_t;

  // Page and offset view of a byte address
  typedef struct packed {
    logic [15:0] page;
    logic [15:0] offset;
  } address_fields_t;

  // Peripherals decode by page, the RAM by the flat address
  typedef union packed {
    logic [31:0]     flat;
    address_fields_t fields;
  } bus_address_u;

endpackage

`default_nettype wire

//--- verilog/periph_pkg.sv
// Register offsets of the GPIO and machine timer register maps

`default_nettype none

package periph_pkg;

  // GPIO map with a read-only IN register
  typedef enum logic [4:0] {
    REG_GPIO_IN  = 5'h00,
    REG_GPIO_OE  = 5'h04,
    REG_GPIO_OUT = 5'h08
  } gpio_reg_t;

  // Timer map with the counter enable in bit 0 of CTRL
  typedef enum logic [4:0] {
    REG_MT_CTRL    = 5'h00,
    REG_MT_TIME_LO = 5'h04,
    REG_MT_TIME_HI = 5'h08,
    REG_MT_CMP_LO  = 5'h0C,
    REG_MT_CMP_HI  = 5'h10
  } mtimer_reg_t;

endpackage

`default_nettype wire

//--- verilog/soc_gpio.sv
// GPIO block: output enable and output registers, synchronized
// input read

`timescale 1ns/1ps
`default_nettype none
`include "soc_settings.svh"

module soc_gpio
  import periph_pkg::*;
(
  input  logic                       clock,
  input  logic                       rst_n,
  input  logic [4:0]                 rw_address,
  input  logic [31:0]                write_data,
  input  logic [3:0]                 write_strobe,
  input  logic                       read_request,
  input  logic                       write_request,
  output logic [31:0]                read_data,
  output logic                       read_response,
  output logic                       write_response,
  input  logic [`SOC_GPIO_WIDTH-1:0] gpio_input,
  output logic [`SOC_GPIO_WIDTH-1:0] gpio_oe,
  output logic [`SOC_GPIO_WIDTH-1:0] gpio_output
);

  localparam int W = `SOC_GPIO_WIDTH;

  gpio_reg_t     reg_select;
  logic [W-1:0]  input_meta;
  logic [W-1:0]  input_sync;

  assign reg_select = gpio_reg_t'(rw_address);

  // Registers, two-stage input synchronizer and responses
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      gpio_oe        <= '0;
      gpio_output    <= '0;
      input_meta     <= '0;
      input_sync     <= '0;
      read_response  <= 1'b0;
      write_response <= 1'b0;
    end else begin
      input_meta     <= gpio_input;
      input_sync     <= input_meta;
      read_response  <= read_request;
      write_response <= write_request;
      if (write_request && write_strobe[0]) begin
        case (reg_select)
          REG_GPIO_OE:  gpio_oe     <= write_data[W-1:0];
          REG_GPIO_OUT: gpio_output <= write_data[W-1:0];
          default: ;
        endcase
      end
    end
  end

  // Read data, zero-extended to the bus width
  always_ff @(posedge clock) begin
    if (read_request) begin
      case (reg_select)
        REG_GPIO_IN:  read_data <= {{(32-W){1'b0}}, input_sync};
        REG_GPIO_OE:  read_data <= {{(32-W){1'b0}}, gpio_oe};
        REG_GPIO_OUT: read_data <= {{(32-W){1'b0}}, gpio_output};
        default:      read_data <= 32'h0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/soc_mtimer.sv
// Machine timer with 64-bit mtime counter, 64-bit mtimecmp and
// registered interrupt level

`timescale 1ns/1ps
`default_nettype none

module soc_mtimer
  import periph_pkg::*;
(
  input  logic        clock,
  input  logic        rst_n,
  input  logic [4:0]  rw_address,
  input  logic [31:0] write_data,
  input  logic [3:0]  write_strobe,
  input  logic        read_request,
  input  logic        write_request,
  output logic [31:0] read_data,
  output logic        read_response,
  output logic        write_response,
  output logic        irq_timer
);

  mtimer_reg_t reg_select;
  logic        enable;
  logic [63:0] mtime;
  logic [63:0] mtimecmp;

  assign reg_select = mtimer_reg_t'(rw_address);

  // Replace only the strobed bytes of a 32-bit half
  function automatic logic [31:0] merge_word(input logic [31:0] old_word,
                                             input logic [31:0] new_word,
                                             input logic [3:0]  strobe);
    logic [31:0] result;
    result = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strobe[i])
        result[8*i +: 8] = new_word[8*i +: 8];
    end
    return result;
  endfunction

  // ----------------------------------------------------------
  // Counter and compare registers
  // ----------------------------------------------------------
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      enable   <= 1'b0;
      mtime    <= 64'h0;
      mtimecmp <= '1;
    end else begin
      if (write_request && reg_select == REG_MT_CTRL && write_strobe[0])
        enable <= write_data[0];

      // A software write wins over the increment
      if (write_request && reg_select == REG_MT_TIME_LO)
        mtime <= {mtime[63:32], merge_word(mtime[31:0], write_data, write_strobe)};
      else if (write_request && reg_select == REG_MT_TIME_HI)
        mtime <= {merge_word(mtime[63:32], write_data, write_strobe), mtime[31:0]};
      else if (enable)
        mtime <= mtime + 64'd1;

      if (write_request && reg_select == REG_MT_CMP_LO)
        mtimecmp[31:0] <= merge_word(mtimecmp[31:0], write_data, write_strobe);
      if (write_request && reg_select == REG_MT_CMP_HI)
        mtimecmp[63:32] <= merge_word(mtimecmp[63:32], write_data, write_strobe);
    end
  end

  // Responses and interrupt level
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      read_response  <= 1'b0;
      write_response <= 1'b0;
      irq_timer      <= 1'b0;
    end else begin
      read_response  <= read_request;
      write_response <= write_request;
      irq_timer      <= (mtime >= mtimecmp);
    end
  end

  always_ff @(posedge clock) begin
    if (read_request) begin
      case (reg_select)
        REG_MT_CTRL:    read_data <= {31'h0, enable};
        REG_MT_TIME_LO: read_data <= mtime[31:0];
        REG_MT_TIME_HI: read_data <= mtime[63:32];
        REG_MT_CMP_LO:  read_data <= mtimecmp[31:0];
        REG_MT_CMP_HI:  read_data <= mtimecmp[63:32];
        default:        read_data <= 32'h0;
      endcase
    end
  end

  // Counter at zero and compare at all ones keep the level low out of reset
  assert property (@(posedge clock) $rose(rst_n) |=> !irq_timer);

endmodule

`default_nettype wire

//--- verilog/soc_ram.sv
// Byte-strobed word RAM with one-cycle read and write responses

`timescale 1ns/1ps
`default_nettype none
`include "soc_settings.svh"

module soc_ram (
  input  logic        clock,
  input  logic        rst_n,
  input  logic [31:0] rw_address,
  input  logic [31:0] write_data,
  input  logic [3:0]  write_strobe,
  input  logic        read_request,
  input  logic        write_request,
  output logic [31:0] read_data,
  output logic        read_response,
  output logic        write_response
);

  localparam int WORDS     = `SOC_MEMORY_SIZE / 4;
  localparam int ADDR_BITS = $clog2(WORDS);

  logic [31:0]          mem [0:WORDS-1];
  logic [ADDR_BITS-1:0] word_index;

  assign word_index = rw_address[ADDR_BITS+1:2];

  // Storage and read register
  always_ff @(posedge clock) begin
    if (write_request) begin
      for (int i = 0; i < 4; i++) begin
        if (write_strobe[i])
          mem[word_index][8*i +: 8] <= write_data[8*i +: 8];
      end
    end
    if (read_request)
      read_data <= mem[word_index];
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      read_response  <= 1'b0;
      write_response <= 1'b0;
    end else begin
      read_response  <= read_request;
      write_response <= write_request;
    end
  end

  assert property (@(posedge clock) disable iff (!rst_n)
    read_response |-> $past(read_request));

  assert property (@(posedge clock) disable iff (!rst_n)
    write_response |-> $past(write_request));

endmodule

`default_nettype wire

//--- verilog/soc_settings.svh
// Memory size, GPIO width and device address map of the SoC
// device subsystem

`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// RAM size in bytes, must be a power of two
`define SOC_MEMORY_SIZE 4096

// Number of GPIO pins
`define SOC_GPIO_WIDTH 4

// ----------------------------------------------------------
// Device base addresses
// ----------------------------------------------------------
`define SOC_RAM_BASE    32'h0000_0000
`define SOC_MTIMER_BASE 32'h8001_0000
`define SOC_GPIO_BASE   32'h8002_0000

// Size of each peripheral region in bytes
`define SOC_PERIPH_REGION 32

`endif

//--- verilog/soc_subsystem.sv
// Device subsystem top: system bus with RAM, GPIO and machine timer

`timescale 1ns/1ps
`default_nettype none
`include "soc_settings.svh"

module soc_subsystem (
  input  logic                       clock,
  input  logic                       rst_n,
  input  logic [31:0]                rw_address,
  input  logic [31:0]                write_data,
  input  logic [3:0]                 write_strobe,
  input  logic                       read_request,
  input  logic                       write_request,
  output logic [31:0]                read_data,
  output logic                       read_response,
  output logic                       write_response,
  input  logic [`SOC_GPIO_WIDTH-1:0] gpio_input,
  output logic [`SOC_GPIO_WIDTH-1:0] gpio_oe,
  output logic [`SOC_GPIO_WIDTH-1:0] gpio_output,
  output logic                       irq_timer
);

  // Shared device bus
  logic [31:0] device_rw_address;
  logic [31:0] device_write_data;
  logic [3:0]  device_write_strobe;

  // Per-device handshake
  logic        ram_read_request,     ram_write_request;
  logic        gpio_read_request,    gpio_write_request;
  logic        mtimer_read_request,  mtimer_write_request;
  logic [31:0] ram_read_data,        gpio_read_data,       mtimer_read_data;
  logic        ram_read_response,    ram_write_response;
  logic        gpio_read_response,   gpio_write_response;
  logic        mtimer_read_response, mtimer_write_response;

  system_bus system_bus_i (
    .clock                 (clock),
    .rst_n                 (rst_n),
    .rw_address            (rw_address),
    .write_data            (write_data),
    .write_strobe          (write_strobe),
    .read_request          (read_request),
    .write_request         (write_request),
    .read_data             (read_data),
    .read_response         (read_response),
    .write_response        (write_response),
    .device_rw_address     (device_rw_address),
    .device_write_data     (device_write_data),
    .device_write_strobe   (device_write_strobe),
    .ram_read_request      (ram_read_request),
    .ram_write_request     (ram_write_request),
    .gpio_read_request     (gpio_read_request),
    .gpio_write_request    (gpio_write_request),
    .mtimer_read_request   (mtimer_read_request),
    .mtimer_write_request  (mtimer_write_request),
    .ram_read_data         (ram_read_data),
    .ram_read_response     (ram_read_response),
    .ram_write_response    (ram_write_response),
    .gpio_read_data        (gpio_read_data),
    .gpio_read_response    (gpio_read_response),
    .gpio_write_response   (gpio_write_response),
    .mtimer_read_data      (mtimer_read_data),
    .mtimer_read_response  (mtimer_read_response),
    .mtimer_write_response (mtimer_write_response)
  );

  soc_ram soc_ram_i (
    .clock          (clock),
    .rst_n          (rst_n),
    .rw_address     (device_rw_address),
    .write_data     (device_write_data),
    .write_strobe   (device_write_strobe),
    .read_request   (ram_read_request),
    .write_request  (ram_write_request),
    .read_data      (ram_read_data),
    .read_response  (ram_read_response),
    .write_response (ram_write_response)
  );

  // Peripherals only see the low offset bits
  soc_gpio soc_gpio_i (
    .clock          (clock),
    .rst_n          (rst_n),
    .rw_address     (device_rw_address[4:0]),
    .write_data     (device_write_data),
    .write_strobe   (device_write_strobe),
    .read_request   (gpio_read_request),
    .write_request  (gpio_write_request),
    .read_data      (gpio_read_data),
    .read_response  (gpio_read_response),
    .write_response (gpio_write_response),
    .gpio_input     (gpio_input),
    .gpio_oe        (gpio_oe),
    .gpio_output    (gpio_output)
  );

  soc_mtimer soc_mtimer_i (
    .clock          (clock),
    .rst_n          (rst_n),
    .rw_address     (device_rw_address[4:0]),
    .write_data     (device_write_data),
    .write_strobe   (device_write_strobe),
    .read_request   (mtimer_read_request),
    .write_request  (mtimer_write_request),
    .read_data      (mtimer_read_data),
    .read_response  (mtimer_read_response),
    .write_response (mtimer_write_response),
    .irq_timer      (irq_timer)
  );

endmodule

`default_nettype wire

//--- verilog/system_bus.sv
// System bus: address decoder, request fan-out to the devices
// and response/read-data mux back to the manager

`timescale 1ns/1ps
`default_nettype none
`include "soc_settings.svh"

module system_bus
  import bus_pkg::*;
(
  input  logic        clock,
  input  logic        rst_n,
  // Manager side
  input  logic [31:0] rw_address,
  input  logic [31:0] write_data,
  input  logic [3:0]  write_strobe,
  input  logic        read_request,
  input  logic        write_request,
  output logic [31:0] read_data,
  output logic        read_response,
  output logic        write_response,
  // Shared device side
  output logic [31:0] device_rw_address,
  output logic [31:0] device_write_data,
  output logic [3:0]  device_write_strobe,
  // Per-device requests
  output logic        ram_read_request,
  output logic        ram_write_request,
  output logic        gpio_read_request,
  output logic        gpio_write_request,
  output logic        mtimer_read_request,
  output logic        mtimer_write_request,
  // Per-device responses
  input  logic [31:0] ram_read_data,
  input  logic        ram_read_response,
  input  logic        ram_write_response,
  input  logic [31:0] gpio_read_data,
  input  logic        gpio_read_response,
  input  logic        gpio_write_response,
  input  logic [31:0] mtimer_read_data,
  input  logic        mtimer_read_response,
  input  logic        mtimer_write_response
);

  localparam logic [31:0] RAM_BASE      = `SOC_RAM_BASE;
  localparam logic [31:0] RAM_SIZE      = `SOC_MEMORY_SIZE;
  localparam logic [31:0] MTIMER_BASE   = `SOC_MTIMER_BASE;
  localparam logic [31:0] GPIO_BASE     = `SOC_GPIO_BASE;
  localparam logic [15:0] PERIPH_REGION = `SOC_PERIPH_REGION;

  bus_address_u  address;
  device_index_t device_select;
  device_index_t device_select_q;
  logic          none_read_response;
  logic          none_write_response;
  logic          request_pending;

  assign address = rw_address;

  // ----------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------
  always_comb begin
    if (address.flat - RAM_BASE < RAM_SIZE)
      device_select = DEV_RAM;
    else if (address.fields.page == MTIMER_BASE[31:16] &&
             address.fields.offset < PERIPH_REGION)
      device_select = DEV_MTIMER;
    else if (address.fields.page == GPIO_BASE[31:16] &&
             address.fields.offset < PERIPH_REGION)
      device_select = DEV_GPIO;
    else
      device_select = DEV_NONE;
  end

  assign device_rw_address   = rw_address;
  assign device_write_data   = write_data;
  assign device_write_strobe = write_strobe;

  // Only the selected device sees the request
  assign ram_read_request     = read_request  && (device_select == DEV_RAM);
  assign ram_write_request    = write_request && (device_select == DEV_RAM);
  assign mtimer_read_request  = read_request  && (device_select == DEV_MTIMER);
  assign mtimer_write_request = write_request && (device_select == DEV_MTIMER);
  assign gpio_read_request    = read_request  && (device_select == DEV_GPIO);
  assign gpio_write_request   = write_request && (device_select == DEV_GPIO);

  // Target of the outstanding request, plus local answer for unmapped
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      device_select_q     <= DEV_NONE;
      none_read_response  <= 1'b0;
      none_write_response <= 1'b0;
      request_pending     <= 1'b0;
    end else begin
      if (read_request || write_request)
        device_select_q <= device_select;
      none_read_response  <= read_request  && (device_select == DEV_NONE);
      none_write_response <= write_request && (device_select == DEV_NONE);
      request_pending     <= read_request || write_request;
    end
  end

  // ----------------------------------------------------------
  // Response mux
  // ----------------------------------------------------------
  always_comb begin
    case (device_select_q)
      DEV_RAM: begin
        read_data      = ram_read_data;
        read_response  = ram_read_response;
        write_response = ram_write_response;
      end
      DEV_MTIMER: begin
        read_data      = mtimer_read_data;
        read_response  = mtimer_read_response;
        write_response = mtimer_write_response;
      end
      DEV_GPIO: begin
        read_data      = gpio_read_data;
        read_response  = gpio_read_response;
        write_response = gpio_write_response;
      end
      default: begin
        read_data      = 32'h0;
        read_response  = none_read_response;
        write_response = none_write_response;
      end
    endcase
  end

  // Manager never raises both requests together
  assert property (@(posedge clock) disable iff (!rst_n)
    !(read_request && write_request));

  // A new request may only overlap the answer to the previous one
  assert property (@(posedge clock) disable iff (!rst_n)
    (request_pending && (read_request || write_request)) |->
      (read_response || write_response));

endmodule

`default_nettype wire
